//--- rtl/cache_data_pkg.sv
`default_nettype none

package cache_data_pkg;

  // geometry of one way of the data store
  localparam int addr_w         = 10;  // word address
  localparam int line_idx_w     = 7;   // upper address bits select the line
  localparam int word_ofs_w     = 3;   // lower address bits select the word
  localparam int word_w         = 32;
  localparam int words_per_line = 8;
  localparam int line_w         = 256; // words_per_line * word_w
  localparam int num_lines      = 128;

  // line is split over four physical banks, two words each
  localparam int num_banks      = 4;
  localparam int bank_w         = 64;
  localparam int bank_be_w      = 8;   // one enable per byte of a bank
  localparam int line_be_w      = 32;  // one enable per byte of a line

  // write opcode, only one kind of write per cycle
  typedef enum logic [1:0] {
    wr_none   = 2'd0,
    wr_store  = 2'd1, // one word, byte masked
    wr_refill = 2'd2  // full line in a single cycle
  } wr_op_e;

  // write request, addr is a word address
  // for a refill only the line index part of addr matters
  typedef struct packed {
    wr_op_e              op;
    logic [addr_w-1:0]   addr;
    logic [3:0]          byte_en; // store byte mask, bit 0 = byte 0 of word
    logic [word_w-1:0]   word;    // store data
    logic [line_w-1:0]   line;    // refill data, word 0 in bits 31:0
  } wr_req_t;

  // read request, single cycle strobe
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
  } rd_req_t;

endpackage

`default_nettype wire

//--- rtl/line_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

// one bank of the line store, two words wide
// behavioural model of a single port block RAM in read-first-free mode
module line_bank_ram
  import cache_data_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  en,
  input  wire logic [bank_be_w-1:0]  be,
  input  wire logic [line_idx_w-1:0] idx,
  input  wire logic [bank_w-1:0]     wdata,
  output logic      [bank_w-1:0]     rdata
);

  logic [bank_w-1:0] mem [num_lines];

  logic do_write;
  logic do_read;

  assign do_write = en && (be != '0);
  assign do_read  = en && (be == '0);

  // byte masked write
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int b = 0; b < bank_be_w; b++) begin
        if (be[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // output register only loads on a read
  // so it keeps the last line through idle and write cycles
  always_ff @(posedge clk) begin
    if (do_read) begin
      rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/store_byte_expand.sv
`timescale 1ns/1ps
`default_nettype none

// spreads a store's byte mask out to the byte enables of a whole line
// word slot ofs gets the mask, every other slot stays zero
module store_byte_expand
  import cache_data_pkg::*;
(
  input  wire logic [word_ofs_w-1:0] ofs,
  input  wire logic [3:0]            byte_en,
  output logic      [line_be_w-1:0]  line_be
);

  // one-hot slot select from the word offset
  logic [words_per_line-1:0] slot_sel;

  always_comb begin
    slot_sel = '0;
    slot_sel[ofs] = 1'b1;
  end

  // each slot takes the mask only when selected
  always_comb begin
    line_be = '0;
    for (int s = 0; s < words_per_line; s++) begin
      if (slot_sel[s]) begin
        line_be[s*(word_w/8) +: (word_w/8)] = byte_en;
      end
    end
  end

  // e.g. ofs = 3, byte_en = 4'b0110
  //   line_be = 32'h0000_6000
  // bytes 13 and 14 of the line

endmodule

`default_nettype wire

//--- rtl/load_word_select.sv
`timescale 1ns/1ps
`default_nettype none

// 8:1 word mux on the line read out of the banks
module load_word_select
  import cache_data_pkg::*;
(
  input  wire logic [line_w-1:0]     line,
  input  wire logic [word_ofs_w-1:0] ofs,
  output logic      [word_w-1:0]     word
);

  // line viewed as an array of words, slot 0 in the low bits
  logic [words_per_line-1:0][word_w-1:0] line_words;

  assign line_words = line;

  always_comb begin
    word = line_words[0];
    for (int s = 1; s < words_per_line; s++) begin
      if (ofs == word_ofs_w'(s)) begin
        word = line_words[s];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/cache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

// data array of one cache way
// single port shared by store, refill and read, writes take priority
// read data shows up one cycle after the accepted read and then holds
module cache_data_array
  import cache_data_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire wr_req_t       wr,
  input  wire rd_req_t       rd,
  output logic [word_w-1:0]  rd_word,
  output logic [line_w-1:0]  rd_line
);

  logic is_write;   // any write opcode this cycle
  logic rd_accept;  // read that actually gets the port
  logic [num_banks-1:0] bank_en;

  logic [addr_w-1:0]     acc_addr;
  logic [line_idx_w-1:0] acc_idx;
  logic [word_ofs_w-1:0] wr_ofs;

  logic [line_be_w-1:0]  store_be;
  logic [line_be_w-1:0]  line_be;
  logic [line_w-1:0]     line_wdata;

  logic [word_ofs_w-1:0] rd_ofs_q;   // offset of the read now at the outputs

  logic [bank_w-1:0] bank_rdata [num_banks];

  // port arbitration
  assign is_write  = (wr.op != wr_none);
  assign rd_accept = rd.en && !is_write; // read in a write cycle is dropped

  assign acc_addr = is_write ? wr.addr : rd.addr;
  assign acc_idx  = acc_addr[addr_w-1 -: line_idx_w];
  assign wr_ofs   = wr.addr[word_ofs_w-1:0];

  store_byte_expand u_store_be (
    .ofs     (wr_ofs),
    .byte_en (wr.byte_en),
    .line_be (store_be)
  );

  // write data and byte enables per opcode
  always_comb begin
    unique case (wr.op)
      wr_store: begin
        line_wdata = {words_per_line{wr.word}}; // every slot, mask picks one
        line_be    = store_be;
      end
      wr_refill: begin
        line_wdata = wr.line;
        line_be    = '1;
      end
      default: begin
        line_wdata = wr.line; // no enables, data is don't care
        line_be    = '0;
      end
    endcase
  end

  // four banks, each holds two words of every line
  for (genvar k = 0; k < num_banks; k++) begin : g_bank
    // untouched banks stay idle on a write so their output holds
    assign bank_en[k] = rd_accept || (line_be[k*bank_be_w +: bank_be_w] != '0);

    line_bank_ram u_bank (
      .clk   (clk),
      .en    (bank_en[k]),
      .be    (line_be[k*bank_be_w +: bank_be_w]),
      .idx   (acc_idx),
      .wdata (line_wdata[k*bank_w +: bank_w]),
      .rdata (bank_rdata[k])
    );

    assign rd_line[k*bank_w +: bank_w] = bank_rdata[k];
  end

  // offset follows the line, so only an accepted read may move it
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ofs_q <= '0;
    end else if (rd_accept) begin
      rd_ofs_q <= rd.addr[word_ofs_w-1:0];
    end
  end

  load_word_select u_word_sel (
    .line (rd_line),
    .ofs  (rd_ofs_q),
    .word (rd_word)
  );

endmodule

`default_nettype wire

//--- rtl/cache_data_top.sv
`timescale 1ns/1ps
`default_nettype none

// top level of the data side of one cache way
//
// request side
//   wr.op     wr_none, wr_store or wr_refill
//   wr.addr   word address, bits 9:3 line index, bits 2:0 word offset
//   wr.byte_en, wr.word   used by a store
//   wr.line   used by a refill
//   rd.en, rd.addr   read strobe and word address
//
// response side
//   rd_line   full line of the last accepted read, for write-back
//   rd_word   word of that line at the read's offset
//
// timing
//   read accepted at edge N, outputs valid after edge N+1
//   a write in the same cycle as a read wins, the read is lost
//   write at edge N is seen by a read at edge N+1 or later
//   outputs hold until the next accepted read
//
// back-to-back reads are fine, one read in the RAM while the
// previous result sits at the outputs
module cache_data_top
  import cache_data_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst,   // clears the read offset only

  // requests
  input  wire wr_req_t       wr,
  input  wire rd_req_t       rd,

  // read data
  output logic [word_w-1:0]  rd_word,
  output logic [line_w-1:0]  rd_line
);

  // all arbitration, steering and storage is in the array
  cache_data_array u_data_array (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd      (rd),
    .rd_word (rd_word),
    .rd_line (rd_line)
  );

endmodule

`default_nettype wire

//--- sim/cache_data_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_tb
  import cache_data_pkg::*;
();

  // one table entry, applied in one clock cycle
  typedef struct packed {
    int                test;
    wr_op_e            op;
    logic [addr_w-1:0] waddr;
    logic [3:0]        be;
    logic [word_w-1:0] word;
    logic [word_w-1:0] pat;   // seed of the refill line
    logic              ren;
    logic [addr_w-1:0] raddr;
    logic              chk;   // outputs compared on the next cycle
  } step_t;

  logic              clk;
  logic              rst;
  wr_req_t           wr;
  rd_req_t           rd;
  logic [word_w-1:0] rd_word;
  logic [line_w-1:0] rd_line;

  step_t             tbl[$];
  logic [line_w-1:0] model_mem [num_lines]; // shadow of the line store
  logic [line_w-1:0] exp_line;
  logic [word_w-1:0] exp_word;
  logic              chk_pending;
  int                cur_test;
  int                test_errs;
  int                total_errs;
  int                checks;
  int                tests_passed;
  int                tests_failed;
  int                cycles;
  int                cycle_limit;
  integer            seed;
  logic [addr_w-1:0] last_waddr;

  cache_data_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd      (rd),
    .rd_word (rd_word),
    .rd_line (rd_line)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // word s of the line is pat plus s times 0x01010101
  function automatic logic [line_w-1:0] pattern_line(input logic [word_w-1:0] pat);
    logic [line_w-1:0] l;
    for (int s = 0; s < words_per_line; s++) begin
      l[s*word_w +: word_w] = pat + s * 32'h0101_0101;
    end
    return l;
  endfunction

  function automatic string test_title(input int t);
    case (t)
      1:       return "refill then word reads";
      2:       return "partial store merge";
      3:       return "store isolation";
      4:       return "write wins the port";
      5:       return "output holding and offset pairing";
      default: return "random stores";
    endcase
  endfunction

  task automatic push_step(input int test, input wr_op_e op, input logic [addr_w-1:0] waddr,
                           input logic [3:0] be, input logic [word_w-1:0] word,
                           input logic [word_w-1:0] pat, input logic ren,
                           input logic [addr_w-1:0] raddr, input logic chk);
    step_t s;
    s.test  = test;
    s.op    = op;
    s.waddr = waddr;
    s.be    = be;
    s.word  = word;
    s.pat   = pat;
    s.ren   = ren;
    s.raddr = raddr;
    s.chk   = chk;
    tbl.push_back(s);
  endtask

  task automatic build_table();
    // 1: refill line 5, then every word of it
    push_step(1, wr_refill, 10'h028, 4'h0, 32'h0, 32'hA000_0010, 1'b0, 10'h000, 1'b0);
    for (int s = 0; s < words_per_line; s++) begin
      push_step(1, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, addr_w'(40 + s), 1'b1);
    end
    // 2: line 9, three masked stores
    push_step(2, wr_refill, 10'h048, 4'h0, 32'h0, 32'h5A5A_0000, 1'b0, 10'h000, 1'b0);
    push_step(2, wr_store, 10'h049, 4'b0001, 32'h1111_11C1, 32'h0, 1'b0, 10'h000, 1'b0);
    push_step(2, wr_store, 10'h04C, 4'b0110, 32'h2222_D222, 32'h0, 1'b0, 10'h000, 1'b0);
    push_step(2, wr_store, 10'h04F, 4'b1000, 32'hE333_3333, 32'h0, 1'b0, 10'h000, 1'b0);
    push_step(2, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h049, 1'b1);
    push_step(2, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h04C, 1'b1);
    push_step(2, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h04F, 1'b1);
    // 3: store into line 10, neighbour line 9 untouched
    push_step(3, wr_refill, 10'h050, 4'h0, 32'h0, 32'h3C00_0000, 1'b0, 10'h000, 1'b0);
    push_step(3, wr_store, 10'h052, 4'b1111, 32'hDEAD_BEEF, 32'h0, 1'b0, 10'h000, 1'b0);
    push_step(3, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h053, 1'b1);
    push_step(3, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h048, 1'b1);
    push_step(3, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h052, 1'b1);
    // 4: read collides with a store and is lost
    push_step(4, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h050, 1'b1);
    push_step(4, wr_store, 10'h051, 4'b1111, 32'hCAFE_F00D, 32'h0, 1'b1, 10'h028, 1'b1);
    push_step(4, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h051, 1'b1);
    // 5: outputs hold through idle cycles and writes to any line
    push_step(5, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h02B, 1'b1);
    push_step(5, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b0, 10'h000, 1'b1);
    push_step(5, wr_store, 10'h02C, 4'b1111, 32'h0BAD_C0DE, 32'h0, 1'b0, 10'h000, 1'b1);
    push_step(5, wr_store, 10'h04E, 4'b0011, 32'h7777_7777, 32'h0, 1'b0, 10'h000, 1'b1);
    push_step(5, wr_refill, 10'h028, 4'h0, 32'h0, 32'hC000_0007, 1'b0, 10'h000, 1'b1);
    push_step(5, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b0, 10'h000, 1'b1);
    push_step(5, wr_none, 10'h000, 4'h0, 32'h0, 32'h0, 1'b1, 10'h02C, 1'b1);
  endtask

  // shadow update for one step, a write drops a read of the same cycle
  task automatic apply_model(input step_t s);
    logic [line_idx_w-1:0] idx;
    logic [word_ofs_w-1:0] ofs;
    idx = s.waddr[addr_w-1 -: line_idx_w];
    ofs = s.waddr[word_ofs_w-1:0];
    case (s.op)
      wr_store: begin
        for (int b = 0; b < 4; b++) begin
          if (s.be[b]) begin
            model_mem[idx][ofs*word_w + 8*b +: 8] = s.word[8*b +: 8];
          end
        end
      end
      wr_refill: begin
        model_mem[idx] = pattern_line(s.pat);
      end
      default: begin
        if (s.ren) begin
          exp_line = model_mem[s.raddr[addr_w-1 -: line_idx_w]];
          exp_word = exp_line[s.raddr[word_ofs_w-1:0]*word_w +: word_w];
        end
      end
    endcase
  endtask

  task automatic compare_outputs();
    checks++;
    if (rd_line !== exp_line) begin
      $display("Error at %0d ns: rd_line expected %h got %h", $time, exp_line, rd_line);
      test_errs++;
    end
    if (rd_word !== exp_word) begin
      $display("Error at %0d ns: rd_word expected %h got %h", $time, exp_word, rd_word);
      test_errs++;
    end
  endtask

  task automatic close_test(input int t);
    if (test_errs == 0) begin
      $display("test %0d (%s) passed", t, test_title(t));
      tests_passed++;
    end else begin
      $display("test %0d (%s) FAILED, %0d errors", t, test_title(t), test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // drive at the edge, compare the previous step between edges
  task automatic run_step(input step_t s);
    wr_req_t w;
    rd_req_t r;
    w.op      = s.op;
    w.addr    = s.waddr;
    w.byte_en = s.be;
    w.word    = s.word;
    w.line    = pattern_line(s.pat);
    r.en      = s.ren;
    r.addr    = s.raddr;
    @(posedge clk);
    wr <= w;
    rd <= r;
    @(negedge clk);
    if (chk_pending) begin
      compare_outputs();
    end
    if (s.test != cur_test) begin
      if (cur_test != 0) begin
        close_test(cur_test);
      end
      cur_test = s.test;
    end
    apply_model(s);
    chk_pending = s.chk;
  endtask

  task automatic random_step();
    step_t       s;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    r = $random(seed);
    a = $random(seed);
    b = $random(seed);
    s = '0;
    s.test  = 6;
    s.chk   = 1'b1;
    s.op    = wr_none;
    s.waddr = a[addr_w-1:0];
    s.be    = (r[7:4] == 4'h0) ? 4'hF : r[7:4]; // empty mask is not a store
    s.word  = $random(seed);
    s.pat   = $random(seed);
    s.raddr = r[8] ? last_waddr : b[addr_w-1:0]; // half the reads hit fresh data
    case (r[1:0])
      2'd0: s.op = wr_refill;
      2'd1: s.op = wr_store;
      2'd2: s.ren = 1'b1;
      default: begin
        s.op  = wr_store;
        s.ren = 1'b1;
      end
    endcase
    if (s.op != wr_none) begin
      last_waddr = s.waddr;
    end
    run_step(s);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    wr           = '0;
    rd           = '0;
    cycles       = 0;
    cycle_limit  = 0;
    seed         = 32'h8fee619a;
    cur_test     = 0;
    test_errs    = 0;
    total_errs   = 0;
    checks       = 0;
    tests_passed = 0;
    tests_failed = 0;
    chk_pending  = 1'b0;
    last_waddr   = 10'h028;
    exp_line     = 'x;
    exp_word     = 'x;
    for (int i = 0; i < num_lines; i++) begin
      model_mem[i] = 'x; // unwritten RAM reads back as x
    end
    build_table();
    cycle_limit = 3 * (tbl.size() + 40) + 20;

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    foreach (tbl[i]) begin
      run_step(tbl[i]);
    end
    for (int n = 0; n < 40; n++) begin
      random_step();
    end
    run_step('0); // idle step, picks up the last compare

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, total_errs);
    if (tests_failed == 0 && total_errs == 0 && checks > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/cache_data_pkg.sv
rtl/line_bank_ram.sv
rtl/store_byte_expand.sv
rtl/load_word_select.sv
rtl/cache_data_array.sv
rtl/cache_data_top.sv
sim/cache_data_tb.sv
